/* common/vram_config.svh */
`ifndef VRAM_CONFIG_SVH
`define VRAM_CONFIG_SVH

//////////////////////////////////////////////////
// xga 1024x768 timing, counted in pixel clocks
//////////////////////////////////////////////////

`define H_ACTIVE      1024
`define H_SYNC_START  1048
`define H_SYNC_END    1184
`define H_TOTAL       1344

`define V_ACTIVE      768
`define V_SYNC_START  777
`define V_SYNC_END    783
`define V_TOTAL       806

//////////////////////////////////////////////////
// frame buffer window and read prefetch
//////////////////////////////////////////////////

// columns of zbt read pipeline to cover
`define READ_AHEAD    4

`define WIN_W         720
`define WIN_H         480

//////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////

`define HCOUNT_W      11
`define VCOUNT_W      10
`define ADDR_W        19
`define WORD_W        36
`define PIXEL_W       18
`define COLOUR_W      8
// one rgb666 channel
`define CHAN_W        6
// free-running bar pattern counter
`define PAT_CNT_W     20

`endif

/* common/vram_pkg.sv */
`include "vram_config.svh"

package vram_pkg;

   // video counters
   typedef logic [`HCOUNT_W-1:0] hcount_t;
   typedef logic [`VCOUNT_W-1:0] vcount_t;

   // zbt word address
   // line number then column bits 9:1
   typedef logic [`ADDR_W-1:0] vram_addr_t;

   // one zbt word holds two pixels
   // even column in the upper half
   typedef logic [`WORD_W-1:0] vram_word_t;

   // rgb666, red in the top bits
   typedef logic [`PIXEL_W-1:0] pixel_t;

   // one dac channel
   typedef logic [`COLOUR_W-1:0] colour_t;

endpackage

/* verilog/xga_timing.sv */
`timescale 1ns/1ps
`include "vram_config.svh"

module xga_timing (
   input  logic              clk,
   input  logic              rst_n,
   output vram_pkg::hcount_t hcount,
   output vram_pkg::vcount_t vcount,
   output logic              hsync,
   output logic              vsync,
   output logic              blank
);

   localparam vram_pkg::hcount_t H_LAST = vram_pkg::hcount_t'(`H_TOTAL - 1);
   localparam vram_pkg::vcount_t V_LAST = vram_pkg::vcount_t'(`V_TOTAL - 1);

   logic              h_last;
   logic              v_last;
   vram_pkg::hcount_t h_next;
   vram_pkg::vcount_t v_next;
   logic              hsync_next;
   logic              vsync_next;
   logic              blank_next;

   //////////////////////////////////////////////////
   // next counter values
   //////////////////////////////////////////////////

   assign h_last = (hcount == H_LAST);
   assign v_last = (vcount == V_LAST);

   assign h_next = h_last ? '0 : hcount + 1'b1;

   // line advances on the last column only
   always_comb begin
      v_next = vcount;
      if (h_last) begin
         v_next = v_last ? '0 : vcount + 1'b1;
      end
   end

   // syncs and blank are decoded from the next count
   // so the registered outputs line up with hcount and vcount
   assign hsync_next = !((h_next >= `H_SYNC_START) && (h_next < `H_SYNC_END));
   assign vsync_next = !((v_next >= `V_SYNC_START) && (v_next < `V_SYNC_END));
   assign blank_next = (h_next >= `H_ACTIVE) || (v_next >= `V_ACTIVE);

   //////////////////////////////////////////////////
   // counters and registered sync outputs
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         hcount <= '0;
         vcount <= '0;
         // syncs are active low
         hsync  <= 1'b1;
         vsync  <= 1'b1;
         // pixel 0,0 is visible
         blank  <= 1'b0;
      end else begin
         hcount <= h_next;
         vcount <= v_next;
         hsync  <= hsync_next;
         vsync  <= vsync_next;
         blank  <= blank_next;
      end
   end

endmodule

/* verilog/bar_pattern.sv */
`timescale 1ns/1ps
`include "vram_config.svh"

module bar_pattern (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 bars_off,
   output vram_pkg::vram_addr_t pat_addr,
   output vram_pkg::vram_word_t pat_data
);

   logic [`PAT_CNT_W-1:0] count;
   vram_pkg::pixel_t      bar_pixel;

   // free-running sweep over the whole memory
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         count <= '0;
      end else begin
         count <= count + 1'b1;
      end
   end

   // two cycles per word address
   assign pat_addr = count[`PAT_CNT_W-1:1];

   // red and blue follow address bits 7:2, green stays dark
   assign bar_pixel = {count[8:3], {`CHAN_W{1'b0}}, count[8:3]};

   // same colour in both halves of the word
   assign pat_data = bars_off ? '0 : {bar_pixel, bar_pixel};

endmodule

/* vram/vram_reader.sv */
`timescale 1ns/1ps
`include "vram_config.svh"

module vram_reader (
   input  logic                 clk,
   input  logic                 rst_n,
   input  vram_pkg::hcount_t    hcount,
   input  vram_pkg::vcount_t    vcount,
   input  logic                 window_off,
   output vram_pkg::vram_addr_t rd_addr,
   input  vram_pkg::vram_word_t rdata,
   output vram_pkg::pixel_t     pixel
);

   // READ_AHEAD spans the zbt read pipeline
   // the next/last latch pair delays each word by one more column pair
   localparam int LOOKAHEAD = `READ_AHEAD + 2;

   localparam vram_pkg::hcount_t H_WRAP = vram_pkg::hcount_t'(`H_TOTAL - LOOKAHEAD);
   localparam vram_pkg::hcount_t H_STEP = vram_pkg::hcount_t'(LOOKAHEAD);
   localparam vram_pkg::vcount_t V_LAST = vram_pkg::vcount_t'(`V_TOTAL - 1);

   vram_pkg::hcount_t    hcount_f;
   vram_pkg::vcount_t    vcount_f;
   vram_pkg::vram_word_t next_word;
   vram_pkg::vram_word_t last_word;
   logic                 in_window;

   //////////////////////////////////////////////////
   // forecast read position
   //////////////////////////////////////////////////

   // wraps past the end of the line onto the next line
   always_comb begin
      if (hcount >= H_WRAP) begin
         hcount_f = hcount - H_WRAP;
         vcount_f = (vcount == V_LAST) ? '0 : vcount + 1'b1;
      end else begin
         hcount_f = hcount + H_STEP;
         vcount_f = vcount;
      end
   end

   // one word per column pair
   assign rd_addr = {vcount_f, hcount_f[9:1]};

   //////////////////////////////////////////////////
   // two-word latch
   //////////////////////////////////////////////////

   // updates on the edge into each even column
   // rdata then holds the word asked for on the last even column
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         next_word <= '0;
         last_word <= '0;
      end else if (hcount[0]) begin
         last_word <= next_word;
         next_word <= rdata;
      end
   end

   //////////////////////////////////////////////////
   // pixel unpack and window
   //////////////////////////////////////////////////

   assign in_window = (hcount < `WIN_W) && (vcount < `WIN_H);

   always_comb begin
      if (!(window_off || in_window)) begin
         // white outside the 720x480 window
         pixel = '1;
      end else if (hcount[0]) begin
         pixel = last_word[`PIXEL_W-1:0];
      end else begin
         pixel = last_word[`WORD_W-1:`PIXEL_W];
      end
   end

endmodule

/* vram/vram_write_arbiter.sv */
`timescale 1ns/1ps

module vram_write_arbiter (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 frame_src,
   input  logic                 blank,
   input  vram_pkg::hcount_t    hcount,
   input  vram_pkg::vram_addr_t rd_addr,
   input  vram_pkg::vram_addr_t pat_addr,
   input  vram_pkg::vram_word_t pat_data,
   input  logic                 wb_cyc,
   input  logic                 wb_stb,
   input  logic                 wb_we,
   input  vram_pkg::vram_addr_t wb_adr,
   input  vram_pkg::vram_word_t wb_dat_w,
   output logic                 wb_ack,
   output logic                 req_we,
   output vram_pkg::vram_addr_t req_addr,
   output vram_pkg::vram_word_t req_wdata
);

   logic src_pat;
   logic wb_wr_req;
   logic wb_rd_req;
   logic host_slot;
   logic pat_slot;
   logic wb_grant;

   // source switch is sampled once so the slot choice never glitches
   // host writes after reset
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         src_pat <= 1'b0;
      end else begin
         src_pat <= frame_src;
      end
   end

   //////////////////////////////////////////////////
   // wishbone classic slave
   //////////////////////////////////////////////////

   assign wb_wr_req = wb_cyc & wb_stb & wb_we;
   assign wb_rd_req = wb_cyc & wb_stb & ~wb_we;

   // host owns the odd columns, pattern owns all of blank
   assign host_slot = ~src_pat & hcount[0];
   assign pat_slot  = src_pat & blank;

   // a pending host write waits for its slot
   assign wb_grant = host_slot & wb_wr_req;

   // reads carry no data and finish at once
   assign wb_ack = wb_grant | wb_rd_req;

   //////////////////////////////////////////////////
   // zbt request
   //////////////////////////////////////////////////

   assign req_we = wb_grant | pat_slot;

   // display read whenever no write is issued
   assign req_addr = wb_grant ? wb_adr :
                     pat_slot ? pat_addr : rd_addr;

   assign req_wdata = src_pat ? pat_data : wb_dat_w;

endmodule

/* vram/zbt_port.sv */
`timescale 1ns/1ps

module zbt_port (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      req_we,
   input  vram_pkg::vram_addr_t      req_addr,
   input  vram_pkg::vram_word_t      req_wdata,
   output vram_pkg::vram_word_t      rdata,
   output vram_pkg::vram_addr_t      zbt_addr,
   output logic                      zbt_we_n,
   output logic                      zbt_cen_n,
   inout  wire vram_pkg::vram_word_t zbt_dq
);

   vram_pkg::vram_word_t wdata_p1;
   vram_pkg::vram_word_t wdata_p2;
   logic                 dq_oe;

   //////////////////////////////////////////////////
   // control pipeline
   //////////////////////////////////////////////////

   // stage 1 puts address and we on the pins
   // stage 2 is the data phase, where dq turns around
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         zbt_we_n  <= 1'b1;
         zbt_cen_n <= 1'b1;
         dq_oe     <= 1'b0;
      end else begin
         zbt_we_n  <= ~req_we;
         // sram clocked only once out of reset
         zbt_cen_n <= 1'b0;
         dq_oe     <= ~zbt_we_n;
      end
   end

   //////////////////////////////////////////////////
   // address and data path
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      zbt_addr <= req_addr;
      // late write data follows the address by one cycle
      wdata_p1 <= req_wdata;
      wdata_p2 <= wdata_p1;
      // data phase of a read, hold otherwise
      if (!dq_oe) begin
         rdata <= zbt_dq;
      end
   end

   assign zbt_dq = dq_oe ? wdata_p2 : 'z;

endmodule

/* verilog/vram_video_top.sv */
`timescale 1ns/1ps
`include "vram_config.svh"

module vram_video_top (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      frame_src,
   input  logic                      bars_off,
   input  logic                      window_off,
   // wishbone host port
   input  logic                      wb_cyc,
   input  logic                      wb_stb,
   input  logic                      wb_we,
   input  vram_pkg::vram_addr_t      wb_adr,
   input  vram_pkg::vram_word_t      wb_dat_w,
   output logic                      wb_ack,
   // zbt sram pins
   output vram_pkg::vram_addr_t      zbt_addr,
   output logic                      zbt_we_n,
   output logic                      zbt_cen_n,
   inout  wire vram_pkg::vram_word_t zbt_dq,
   // vga dac
   output vram_pkg::colour_t         vga_red,
   output vram_pkg::colour_t         vga_green,
   output vram_pkg::colour_t         vga_blue,
   output logic                      vga_blank_n,
   output logic                      vga_hsync,
   output logic                      vga_vsync
);

   localparam int PAD_W = `COLOUR_W - `CHAN_W;

   vram_pkg::hcount_t    hcount;
   vram_pkg::vcount_t    vcount;
   logic                 hsync;
   logic                 vsync;
   logic                 blank;
   vram_pkg::vram_addr_t pat_addr;
   vram_pkg::vram_word_t pat_data;
   vram_pkg::vram_addr_t rd_addr;
   vram_pkg::vram_word_t rdata;
   vram_pkg::pixel_t     pixel;
   vram_pkg::pixel_t     pixel_q;
   logic                 req_we;
   vram_pkg::vram_addr_t req_addr;
   vram_pkg::vram_word_t req_wdata;

   //////////////////////////////////////////////////
   // timing, sources and memory port
   //////////////////////////////////////////////////

   xga_timing u_timing (
      .clk    (clk),
      .rst_n  (rst_n),
      .hcount (hcount),
      .vcount (vcount),
      .hsync  (hsync),
      .vsync  (vsync),
      .blank  (blank)
   );

   bar_pattern u_bars (
      .clk      (clk),
      .rst_n    (rst_n),
      .bars_off (bars_off),
      .pat_addr (pat_addr),
      .pat_data (pat_data)
   );

   vram_write_arbiter u_arb (
      .clk       (clk),
      .rst_n     (rst_n),
      .frame_src (frame_src),
      .blank     (blank),
      .hcount    (hcount),
      .rd_addr   (rd_addr),
      .pat_addr  (pat_addr),
      .pat_data  (pat_data),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_dat_w  (wb_dat_w),
      .wb_ack    (wb_ack),
      .req_we    (req_we),
      .req_addr  (req_addr),
      .req_wdata (req_wdata)
   );

   zbt_port u_zbt (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_we    (req_we),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .rdata     (rdata),
      .zbt_addr  (zbt_addr),
      .zbt_we_n  (zbt_we_n),
      .zbt_cen_n (zbt_cen_n),
      .zbt_dq    (zbt_dq)
   );

   vram_reader u_reader (
      .clk        (clk),
      .rst_n      (rst_n),
      .hcount     (hcount),
      .vcount     (vcount),
      .window_off (window_off),
      .rd_addr    (rd_addr),
      .rdata      (rdata),
      .pixel      (pixel)
   );

   //////////////////////////////////////////////////
   // output registers
   //////////////////////////////////////////////////

   // pixel and syncs take the same extra stage
   always_ff @(posedge clk) begin
      pixel_q <= pixel;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         vga_blank_n <= 1'b0;
         vga_hsync   <= 1'b1;
         vga_vsync   <= 1'b1;
      end else begin
         vga_blank_n <= ~blank;
         vga_hsync   <= hsync;
         vga_vsync   <= vsync;
      end
   end

   // 6-bit channels sit in the top of each 8-bit dac input
   assign vga_red   = {pixel_q[3*`CHAN_W-1:2*`CHAN_W], {PAD_W{1'b0}}};
   assign vga_green = {pixel_q[2*`CHAN_W-1:`CHAN_W], {PAD_W{1'b0}}};
   assign vga_blue  = {pixel_q[`CHAN_W-1:0], {PAD_W{1'b0}}};

endmodule

/* tb/zbt_sram_model.sv */
`timescale 1ns/1ps
`include "vram_config.svh"

module zbt_sram_model (
   input  logic                      clk,
   input  vram_pkg::vram_addr_t      addr,
   input  logic                      we_n,
   input  logic                      cen_n,
   inout  wire vram_pkg::vram_word_t dq,
   // one pulse per committed write
   output logic                      log_valid,
   output vram_pkg::vram_addr_t      log_addr,
   output vram_pkg::vram_word_t      log_data
);

   localparam int DEPTH = 1 << `ADDR_W;

   vram_pkg::vram_word_t mem [DEPTH];
   vram_pkg::vram_addr_t addr_q;
   vram_pkg::vram_word_t rd_word;
   logic                 wr_phase;
   logic                 rd_phase;

   // unwritten words still differ per address
   function automatic vram_pkg::vram_word_t fill_word(input vram_pkg::vram_addr_t a);
      return {a, ~a[16:0]};
   endfunction

   initial begin : fill_mem
      int i;
      for (i = 0; i < DEPTH; i++) begin
         mem[i] = fill_word(vram_pkg::vram_addr_t'(i));
      end
      wr_phase  = 1'b0;
      rd_phase  = 1'b0;
      log_valid = 1'b0;
   end

   //////////////////////////////////////////////////
   // pipelined zbt, late write
   //////////////////////////////////////////////////

   // edge 1 takes the address, edge 2 is the data phase
   always @(posedge clk) begin
      log_valid <= 1'b0;
      if (wr_phase) begin
         mem[addr_q] <= dq;
         log_valid   <= 1'b1;
         log_addr    <= addr_q;
         log_data    <= dq;
      end
      wr_phase <= !cen_n && !we_n;
      rd_phase <= !cen_n && we_n;
      addr_q   <= addr;
      rd_word  <= mem[addr];
   end

   // read data on the bus for the whole data phase
   assign dq = rd_phase ? rd_word : 'z;

endmodule

/* tb/tb_vram_video.sv */
`timescale 1ns/1ps
`include "vram_config.svh"

module tb_vram_video;

   localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
   localparam int LINE_WORDS   = `H_ACTIVE / 2;
   localparam int N_STEPS      = 8;
   localparam int SIG_VSYNC    = 0;
   localparam int SIG_BLANK    = 1;

   localparam logic [2:0] OP_SYNC    = 3'd0;
   localparam logic [2:0] OP_HOST    = 3'd1;
   localparam logic [2:0] OP_DISPLAY = 3'd2;
   localparam logic [2:0] OP_STALL   = 3'd3;
   localparam logic [2:0] OP_PATTERN = 3'd4;

   // one row of the stimulus table
   typedef struct packed {
      logic [2:0] op;
      logic       frame_src;
      logic       bars_off;
      logic       window_off;
      logic [9:0] line;
      logic [7:0] fill;
   } step_t;

   logic                      clk;
   logic                      rst_n;
   logic                      frame_src;
   logic                      bars_off;
   logic                      window_off;
   logic                      wb_cyc;
   logic                      wb_stb;
   logic                      wb_we;
   vram_pkg::vram_addr_t      wb_adr;
   vram_pkg::vram_word_t      wb_dat_w;
   logic                      wb_ack;
   vram_pkg::vram_addr_t      zbt_addr;
   logic                      zbt_we_n;
   logic                      zbt_cen_n;
   wire vram_pkg::vram_word_t zbt_dq;
   vram_pkg::colour_t         vga_red;
   vram_pkg::colour_t         vga_green;
   vram_pkg::colour_t         vga_blue;
   logic                      vga_blank_n;
   logic                      vga_hsync;
   logic                      vga_vsync;
   logic                      log_valid;
   vram_pkg::vram_addr_t      log_addr;
   vram_pkg::vram_word_t      log_data;

   step_t                steps [N_STEPS];
   vram_pkg::vram_word_t exp_word [2][LINE_WORDS];
   vram_pkg::vram_addr_t wr_addr_q [$];
   vram_pkg::vram_word_t wr_data_q [$];
   logic [15:0]          lfsr;
   logic                 pat_watch;

   vram_video_top dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .frame_src   (frame_src),
      .bars_off    (bars_off),
      .window_off  (window_off),
      .wb_cyc      (wb_cyc),
      .wb_stb      (wb_stb),
      .wb_we       (wb_we),
      .wb_adr      (wb_adr),
      .wb_dat_w    (wb_dat_w),
      .wb_ack      (wb_ack),
      .zbt_addr    (zbt_addr),
      .zbt_we_n    (zbt_we_n),
      .zbt_cen_n   (zbt_cen_n),
      .zbt_dq      (zbt_dq),
      .vga_red     (vga_red),
      .vga_green   (vga_green),
      .vga_blue    (vga_blue),
      .vga_blank_n (vga_blank_n),
      .vga_hsync   (vga_hsync),
      .vga_vsync   (vga_vsync)
   );

   zbt_sram_model sram (
      .clk       (clk),
      .addr      (zbt_addr),
      .we_n      (zbt_we_n),
      .cen_n     (zbt_cen_n),
      .dq        (zbt_dq),
      .log_valid (log_valid),
      .log_addr  (log_addr),
      .log_data  (log_data)
   );

   // 25 MHz pixel clock
   always #20 clk = ~clk;

   // collect every write the sram commits
   always @(negedge clk) begin
      if (log_valid) begin
         wr_addr_q.push_back(log_addr);
         wr_data_q.push_back(log_data);
      end
   end

   // pattern writes reach the pins only in blanking
   always @(negedge clk) begin
      if (pat_watch && !zbt_we_n) begin
         check("vga_blank_n", vga_blank_n, 1'b0);
      end
   end

   //////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////

   task stop_on_error;
      $display("FAIL: see errors above");
      $fatal(1, "stopping at first error");
   endtask

   task check(input string name, input logic [35:0] got, input logic [35:0] exp);
      if (got !== exp) begin
         $display("ERR %s got %h exp %h", name, got, exp);
         stop_on_error();
      end
   endtask

   task report_timeout(input string what);
      $display("timeout while waiting for %s", what);
      stop_on_error();
   endtask

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task rand_word(output vram_pkg::vram_word_t w);
      int i;
      w = '0;
      for (i = 0; i < `WORD_W; i++) begin
         lfsr = lfsr_next(lfsr);
         w    = {w[`WORD_W-2:0], lfsr[0]};
      end
   endtask

   function automatic logic sig_val(input int which);
      if (which == SIG_VSYNC) begin
         return vga_vsync;
      end
      return vga_blank_n;
   endfunction

   // returns on the first sample at the new level
   task wait_edge(input int which, input logic level, input string what);
      int n;
      n = 0;
      while (sig_val(which) == level) begin
         if (n == FRAME_CYCLES) report_timeout(what);
         @(negedge clk);
         n++;
      end
      n = 0;
      while (sig_val(which) != level) begin
         if (n == FRAME_CYCLES) report_timeout(what);
         @(negedge clk);
         n++;
      end
   endtask

   //////////////////////////////////////////////////
   // test steps
   //////////////////////////////////////////////////

   task check_sync;
      int   n;
      int   last_fall;
      int   hs_low;
      int   vs_low;
      int   bl_high;
      int   lines;
      logic hs_q;
      logic bl_q;
      wait_edge(SIG_VSYNC, 1'b0, "vga_vsync to fall");
      hs_q      = vga_hsync;
      bl_q      = vga_blank_n;
      last_fall = -1;
      hs_low    = 0;
      vs_low    = 0;
      bl_high   = 0;
      lines     = 0;
      // exactly one frame from the vsync edge
      for (n = 0; n < FRAME_CYCLES; n++) begin
         if (!vga_vsync) vs_low++;
         if (hs_q && !vga_hsync) begin
            if (last_fall >= 0) check("vga_hsync period", n - last_fall, `H_TOTAL);
            last_fall = n;
         end
         if (!vga_hsync) hs_low++;
         if (!hs_q && vga_hsync) begin
            check("vga_hsync low", hs_low, `H_SYNC_END - `H_SYNC_START);
            hs_low = 0;
         end
         if (vga_blank_n) bl_high++;
         if (bl_q && !vga_blank_n) begin
            check("vga_blank_n high", bl_high, `H_ACTIVE);
            bl_high = 0;
            lines++;
         end
         hs_q = vga_hsync;
         bl_q = vga_blank_n;
         @(negedge clk);
      end
      check("vga_vsync low", vs_low, (`V_SYNC_END - `V_SYNC_START) * `H_TOTAL);
      check("visible lines", lines, `V_ACTIVE);
   endtask

   // one classic write, ack looked at mid-cycle
   task host_write(input vram_pkg::vram_addr_t a, input vram_pkg::vram_word_t d);
      int   n;
      logic acked;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = 1'b1;
      wb_adr   = a;
      wb_dat_w = d;
      acked    = 1'b0;
      n        = 0;
      while (!acked) begin
         if (n == 2) report_timeout("wb_ack within two cycles of a host write");
         #1;
         acked = wb_ack;
         @(negedge clk);
         n++;
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      #1;
      check("wb_ack", wb_ack, 1'b0);
      @(negedge clk);
   endtask

   task write_line(input logic [9:0] line);
      int                   w;
      int                   idx;
      vram_pkg::vram_word_t d;
      idx = line - 10;
      repeat (4) @(negedge clk);
      wr_addr_q.delete();
      wr_data_q.delete();
      for (w = 0; w < LINE_WORDS; w++) begin
         rand_word(d);
         exp_word[idx][w] = d;
         host_write({line, w[8:0]}, d);
      end
      // let the late write drain into the log
      repeat (4) @(negedge clk);
      check("write log size", wr_addr_q.size(), LINE_WORDS);
      for (w = 0; w < LINE_WORDS; w++) begin
         check("zbt_addr", wr_addr_q[w], {line, w[8:0]});
         check("zbt_dq", wr_data_q[w], exp_word[idx][w]);
      end
   endtask

   // lines 10 and 11 of the next frame
   task check_display(input vram_pkg::colour_t fill);
      int                   line;
      int                   col;
      vram_pkg::vram_word_t word;
      vram_pkg::pixel_t     half;
      wait_edge(SIG_VSYNC, 1'b0, "vga_vsync to fall");
      for (line = 0; line < 12; line++) begin
         wait_edge(SIG_BLANK, 1'b1, "vga_blank_n to rise");
         if (line >= 10) begin
            for (col = 0; col < `H_ACTIVE; col++) begin
               word = exp_word[line - 10][col / 2];
               // even column in the upper half
               half = col[0] ? word[17:0] : word[35:18];
               if (col < `WIN_W || window_off) begin
                  check("vga_red", vga_red, {half[17:12], 2'b00});
                  check("vga_green", vga_green, {half[11:6], 2'b00});
                  check("vga_blue", vga_blue, {half[5:0], 2'b00});
               end else begin
                  check("vga_red", vga_red, fill);
                  check("vga_green", vga_green, fill);
                  check("vga_blue", vga_blue, fill);
               end
               @(negedge clk);
            end
         end
      end
   endtask

   // host write held for a full line in pattern mode
   task check_stall(input logic [9:0] line);
      int n;
      repeat (2) @(negedge clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = 1'b1;
      wb_adr   = {line, 9'd0};
      wb_dat_w = '1;
      for (n = 0; n < `H_TOTAL; n++) begin
         #1;
         check("wb_ack", wb_ack, 1'b0);
         @(negedge clk);
      end
      // a read finishes at once even while writes stall
      wb_we = 1'b0;
      #1;
      check("wb_ack", wb_ack, 1'b1);
      @(negedge clk);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      @(negedge clk);
   endtask

   task check_pattern(input logic zero_data);
      int                   i;
      vram_pkg::vram_addr_t a;
      vram_pkg::pixel_t     half;
      repeat (4) @(negedge clk);
      wr_addr_q.delete();
      wr_data_q.delete();
      pat_watch = 1'b1;
      // two lines hold at least two horizontal blanks
      repeat (2 * `H_TOTAL) @(negedge clk);
      pat_watch = 1'b0;
      if (wr_addr_q.size() == 0) begin
         $display("no pattern writes were seen over two lines");
         stop_on_error();
      end
      for (i = 0; i < wr_addr_q.size(); i++) begin
         a    = wr_addr_q[i];
         half = zero_data ? '0 : {a[7:2], 6'd0, a[7:2]};
         check("zbt_dq", wr_data_q[i], {half, half});
      end
   endtask

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////

   initial begin
      int s;
      clk        = 1'b0;
      rst_n      = 1'b0;
      frame_src  = 1'b0;
      bars_off   = 1'b0;
      window_off = 1'b0;
      wb_cyc     = 1'b0;
      wb_stb     = 1'b0;
      wb_we      = 1'b0;
      wb_adr     = '0;
      wb_dat_w   = '0;
      pat_watch  = 1'b0;
      lfsr       = 16'd1794;

      // op, frame_src, bars_off, window_off, line, fill colour
      steps[0] = {OP_SYNC, 1'b0, 1'b0, 1'b0, 10'd0, 8'hFC};
      steps[1] = {OP_HOST, 1'b0, 1'b0, 1'b0, 10'd10, 8'hFC};
      steps[2] = {OP_HOST, 1'b0, 1'b0, 1'b0, 10'd11, 8'hFC};
      steps[3] = {OP_DISPLAY, 1'b0, 1'b0, 1'b0, 10'd10, 8'hFC};
      steps[4] = {OP_DISPLAY, 1'b0, 1'b0, 1'b1, 10'd10, 8'hFC};
      steps[5] = {OP_STALL, 1'b1, 1'b0, 1'b0, 10'd700, 8'hFC};
      steps[6] = {OP_PATTERN, 1'b1, 1'b0, 1'b0, 10'd0, 8'hFC};
      steps[7] = {OP_PATTERN, 1'b1, 1'b1, 1'b0, 10'd0, 8'hFC};

      repeat (10) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      // idle bus and sram enabled once out of reset
      check("wb_ack", wb_ack, 1'b0);
      check("zbt_we_n", zbt_we_n, 1'b1);
      check("zbt_cen_n", zbt_cen_n, 1'b0);

      for (s = 0; s < N_STEPS; s++) begin
         frame_src  = steps[s].frame_src;
         bars_off   = steps[s].bars_off;
         window_off = steps[s].window_off;
         case (steps[s].op)
            OP_SYNC:    check_sync();
            OP_HOST:    write_line(steps[s].line);
            OP_DISPLAY: check_display(steps[s].fill);
            OP_STALL:   check_stall(steps[s].line);
            default:    check_pattern(steps[s].bars_off);
         endcase
      end

      $display("PASS: all tests");
      $finish;
   end

endmodule

/* vram_video_top.f */
+incdir+common
common/vram_pkg.sv
verilog/xga_timing.sv
verilog/bar_pattern.sv
vram/vram_reader.sv
vram/vram_write_arbiter.sv
vram/zbt_port.sv
verilog/vram_video_top.sv
tb/zbt_sram_model.sv
tb/tb_vram_video.sv

/* Bender.yml */
package:
  name: vram_video

export_include_dirs:
  - common

sources:
  - files:
      - common/vram_pkg.sv
      - verilog/xga_timing.sv
      - verilog/bar_pattern.sv
      - vram/vram_reader.sv
      - vram/vram_write_arbiter.sv
      - vram/zbt_port.sv
      - verilog/vram_video_top.sv

  - target: test
    files:
      - tb/zbt_sram_model.sv
      - tb/tb_vram_video.sv
